/* ip_hdr_pkg.sv */
package ip_hdr_pkg;

    // ethernet header fields
    localparam int mac_w       = 48;
    localparam int ethertype_w = 16;

    // ipv4 header fields
    localparam int ip_addr_w = 32;
    localparam int ip_len_w  = 16;
    localparam int dscp_w    = 6;
    localparam int ecn_w     = 2;
    localparam int flags_w   = 3;
    localparam int frag_w    = 13;
    localparam int ttl_w     = 8;

    // version 4, ihl 5, no options supported
    localparam logic [7:0] ip_ver_ihl = 8'h45;
    localparam int ip_hdr_bytes       = 20;

    // nine 16-bit terms never carry past bit 19
    localparam int csum_acc_w = 20;

endpackage

/* ip_stream_pkg.sv */
package ip_stream_pkg;

    localparam int data_w     = 64;
    localparam int keep_w     = 8;
    // header is 20 bytes, so payload lands half a word off
    localparam int half_bytes = 4;

    typedef enum logic [2:0] {
        idle,
        hdr_word0,
        hdr_word1,
        hdr_merge,
        payload,
        drain_excess,
        drain_error
    } tx_state_e;

    // number of set bits counted up from bit 0
    function automatic logic [3:0] keep2count(input logic [keep_w-1:0] keep);
        logic [3:0] n;
        n = 4'd0;
        for (int i = 0; i < keep_w; i++) begin
            if (keep[i] && n == 4'(i)) begin
                n = n + 4'd1;
            end
        end
        return n;
    endfunction

    function automatic logic [keep_w-1:0] count2keep(input logic [3:0] count);
        logic [keep_w-1:0] keep;
        for (int i = 0; i < keep_w; i++) begin
            keep[i] = 4'(i) < count;
        end
        return keep;
    endfunction

endpackage

/* ip_hdr_capture.sv */
`timescale 1ns/100ps

module ip_hdr_capture
    import ip_hdr_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   hdr_accept,
    input  logic [mac_w-1:0]       dest_mac,
    input  logic [mac_w-1:0]       src_mac,
    input  logic [ethertype_w-1:0] eth_type,
    input  logic [dscp_w-1:0]      dscp,
    input  logic [ecn_w-1:0]       ecn,
    input  logic [ip_len_w-1:0]    length,
    input  logic [ip_len_w-1:0]    identification,
    input  logic [flags_w-1:0]     flags,
    input  logic [frag_w-1:0]      frag_offset,
    input  logic [ttl_w-1:0]       ttl,
    input  logic [ttl_w-1:0]       protocol,
    input  logic [ip_addr_w-1:0]   src_ip,
    input  logic [ip_addr_w-1:0]   dest_ip,
    input  logic                   m_eth_hdr_ready,
    output logic                   m_eth_hdr_valid,
    output logic [mac_w-1:0]       m_eth_dest_mac,
    output logic [mac_w-1:0]       m_eth_src_mac,
    output logic [ethertype_w-1:0] m_eth_type,
    output logic [63:0]            hdr_word0,
    output logic [63:0]            hdr_word1,
    output logic [ip_addr_w-1:0]   dest_ip_q,
    output logic [ip_len_w-1:0]    ip_length_q
);

    logic [dscp_w-1:0]     dscp_q;
    logic [ecn_w-1:0]      ecn_q;
    logic [ip_len_w-1:0]   ident_q;
    logic [flags_w-1:0]    flags_q;
    logic [frag_w-1:0]     frag_q;
    logic [ttl_w-1:0]      ttl_q;
    logic [ttl_w-1:0]      proto_q;
    logic [ip_addr_w-1:0]  src_ip_q;
    logic [csum_acc_w-1:0] csum_sum;
    logic [csum_acc_w-1:0] csum_sum_q;
    logic [16:0]           fold1;
    logic [15:0]           fold2;

    // ones-complement sum of the header, checksum field taken as zero
    assign csum_sum = {ip_ver_ihl, dscp, ecn} + length + identification
                    + {flags, frag_offset} + {ttl, protocol}
                    + src_ip[31:16] + src_ip[15:0] + dest_ip[31:16] + dest_ip[15:0];

    // second fold catches the carry of the first
    assign fold1 = {1'b0, csum_sum_q[15:0]} + 17'(csum_sum_q[csum_acc_w-1:16]);
    assign fold2 = fold1[15:0] + 16'(fold1[16]);

    // network byte order, byte 0 in bits 7:0
    assign hdr_word0 = {frag_q[7:0], flags_q, frag_q[12:8], ident_q[7:0], ident_q[15:8],
                        ip_length_q[7:0], ip_length_q[15:8], dscp_q, ecn_q, ip_ver_ihl};
    assign hdr_word1 = {src_ip_q[7:0], src_ip_q[15:8], src_ip_q[23:16], src_ip_q[31:24],
                        ~fold2[7:0], ~fold2[15:8], proto_q, ttl_q};

    always_ff @(posedge clk) begin
        if (rst) begin
            m_eth_hdr_valid <= 1'b0;
        end else if (hdr_accept) begin
            m_eth_hdr_valid <= 1'b1;
        end else if (m_eth_hdr_ready) begin
            m_eth_hdr_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (hdr_accept) begin
            m_eth_dest_mac <= dest_mac;
            m_eth_src_mac  <= src_mac;
            m_eth_type     <= eth_type;
            dscp_q         <= dscp;
            ecn_q          <= ecn;
            ip_length_q    <= length;
            ident_q        <= identification;
            flags_q        <= flags;
            frag_q         <= frag_offset;
            ttl_q          <= ttl;
            proto_q        <= protocol;
            src_ip_q       <= src_ip;
            dest_ip_q      <= dest_ip;
            csum_sum_q     <= csum_sum;
        end
    end

    // next header must wait until this one is taken
    assert property (@(posedge clk) disable iff (rst)
        m_eth_hdr_valid && !m_eth_hdr_ready |=> m_eth_hdr_valid && $stable(m_eth_dest_mac)
            && $stable(m_eth_src_mac) && $stable(m_eth_type));

endmodule

/* ip_payload_shifter.sv */
`timescale 1ns/100ps

module ip_payload_shifter
    import ip_stream_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic [data_w-1:0] s_tdata,
    input  logic [keep_w-1:0] s_tkeep,
    input  logic              s_tvalid,
    input  logic              s_tlast,
    input  logic              save_en,
    input  logic              flush,
    output logic [data_w-1:0] shift_tdata,
    output logic [keep_w-1:0] shift_tkeep,
    output logic              shift_tvalid,
    output logic              shift_tlast,
    output logic              shift_in_ready
);

    logic [data_w-1:0] save_data;
    logic [keep_w-1:0] save_keep;
    logic              last_q;
    logic              extra_q;

    always_comb begin
        // low half always comes from the previous word
        shift_tdata[half_bytes*8-1:0] = save_data[data_w-1:half_bytes*8];
        shift_tkeep[half_bytes-1:0]   = save_keep[keep_w-1:half_bytes];
        if (extra_q) begin
            shift_tdata[data_w-1:half_bytes*8] = '0;
            shift_tkeep[keep_w-1:half_bytes]   = '0;
            shift_tvalid = 1'b1;
            shift_tlast  = 1'b1;
        end else begin
            shift_tdata[data_w-1:half_bytes*8] = s_tdata[half_bytes*8-1:0];
            shift_tkeep[keep_w-1:half_bytes]   = s_tkeep[half_bytes-1:0];
            shift_tvalid = s_tvalid;
            // last only if nothing spills into a flush word
            shift_tlast  = s_tlast && s_tkeep[keep_w-1:half_bytes] == '0;
        end
    end

    // hold off input from the end of a frame until flushed
    assign shift_in_ready = !extra_q && !last_q && !(save_en && s_tlast);

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            last_q  <= 1'b0;
            extra_q <= 1'b0;
        end else if (save_en) begin
            last_q  <= s_tlast;
            extra_q <= s_tlast && s_tkeep[keep_w-1:half_bytes] != '0;
        end
    end

    always_ff @(posedge clk) begin
        if (save_en) begin
            save_data <= s_tdata;
            save_keep <= s_tkeep;
        end
    end

endmodule

/* ip_tx_ctrl.sv */
`timescale 1ns/100ps

module ip_tx_ctrl
    import ip_hdr_pkg::*;
    import ip_stream_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 s_ip_hdr_valid,
    output logic                 s_ip_hdr_ready,
    output logic                 hdr_accept,
    input  logic                 m_eth_hdr_valid,
    input  logic [data_w-1:0]    hdr_word0,
    input  logic [data_w-1:0]    hdr_word1,
    input  logic [ip_addr_w-1:0] dest_ip_q,
    input  logic [ip_len_w-1:0]  ip_length_q,
    input  logic                 s_payload_tvalid,
    input  logic                 s_payload_tlast,
    output logic                 s_payload_tready,
    input  logic [data_w-1:0]    shift_tdata,
    input  logic [keep_w-1:0]    shift_tkeep,
    input  logic                 shift_tvalid,
    input  logic                 shift_tlast,
    input  logic                 shift_in_ready,
    output logic                 save_en,
    output logic                 flush,
    output logic [data_w-1:0]    int_tdata,
    output logic [keep_w-1:0]    int_tkeep,
    output logic                 int_tvalid,
    output logic                 int_tlast,
    output logic                 int_tuser,
    input  logic                 int_ready_reg,
    input  logic                 int_ready_early,
    output logic                 error_early_term
);

    tx_state_e             state;
    tx_state_e             state_next;
    logic                  hdr_ready_next;
    logic                  tready_next;
    logic [ip_len_w-1:0]   bytes_left;
    logic [ip_len_w-1:0]   bytes_left_next;
    logic [data_w-1:0]     word_data;
    logic [keep_w-1:0]     word_keep;
    logic [3:0]            word_count;
    logic                  word_go;
    logic                  in_go;
    logic                  in_done;

    assign hdr_accept       = s_ip_hdr_ready && s_ip_hdr_valid;
    assign in_go            = s_payload_tready && s_payload_tvalid;
    assign save_en          = in_go;
    assign flush            = state == idle;
    assign error_early_term = state == drain_error;
    // input side has seen its last word, flush word included
    assign in_done          = shift_tlast || (in_go && s_payload_tlast);

    // first payload word shares its low half with the destination address
    always_comb begin
        if (state == hdr_merge) begin
            word_data = {shift_tdata[data_w-1:half_bytes*8], dest_ip_q[7:0],
                         dest_ip_q[15:8], dest_ip_q[23:16], dest_ip_q[31:24]};
            word_keep = {shift_tkeep[keep_w-1:half_bytes], {half_bytes{1'b1}}};
            word_go   = in_go;
        end else begin
            word_data = shift_tdata;
            word_keep = shift_tkeep;
            word_go   = int_ready_reg && shift_tvalid;
        end
    end

    assign word_count = keep2count(word_keep);

    always_comb begin
        state_next      = state;
        hdr_ready_next  = 1'b0;
        tready_next     = 1'b0;
        bytes_left_next = bytes_left;
        int_tdata       = word_data;
        int_tkeep       = word_keep;
        int_tvalid      = 1'b0;
        int_tlast       = 1'b0;
        int_tuser       = 1'b0;
        case (state)
            idle: begin
                hdr_ready_next = !m_eth_hdr_valid;
                if (hdr_accept) begin
                    hdr_ready_next = 1'b0;
                    state_next     = ip_stream_pkg::hdr_word0;
                end
            end
            ip_stream_pkg::hdr_word0: begin
                // dest ip goes out with the payload, so it counts here
                bytes_left_next = ip_length_q - ip_len_w'(ip_hdr_bytes - half_bytes);
                if (int_ready_reg) begin
                    int_tvalid = 1'b1;
                    int_tdata  = hdr_word0;
                    int_tkeep  = '1;
                    state_next = ip_stream_pkg::hdr_word1;
                end
            end
            ip_stream_pkg::hdr_word1: begin
                if (int_ready_reg) begin
                    int_tvalid  = 1'b1;
                    int_tdata   = hdr_word1;
                    int_tkeep   = '1;
                    tready_next = int_ready_early && shift_in_ready;
                    state_next  = hdr_merge;
                end
            end
            hdr_merge, payload: begin
                tready_next = int_ready_early && shift_in_ready;
                if (word_go) begin
                    int_tvalid      = 1'b1;
                    bytes_left_next = bytes_left - ip_len_w'(keep_w);
                    state_next      = payload;
                    if (ip_len_w'(word_count) >= bytes_left) begin
                        // length reached, trim and close the frame
                        int_tkeep = count2keep(bytes_left[3:0]);
                        int_tlast = 1'b1;
                        if (in_done) begin
                            tready_next = 1'b0;
                            state_next  = idle;
                        end else begin
                            tready_next = shift_in_ready;
                            state_next  = drain_excess;
                        end
                    end else if (shift_tlast) begin
                        // input ran out before the length field
                        int_tlast   = 1'b1;
                        int_tuser   = 1'b1;
                        tready_next = 1'b0;
                        state_next  = drain_error;
                    end
                end
            end
            drain_excess: begin
                tready_next = shift_in_ready;
                if (in_go && s_payload_tlast) begin
                    state_next = idle;
                end
            end
            drain_error: begin
                state_next = idle;
            end
            default: begin
                state_next = idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state            <= idle;
            s_ip_hdr_ready   <= 1'b0;
            s_payload_tready <= 1'b0;
            bytes_left       <= '0;
        end else begin
            state            <= state_next;
            s_ip_hdr_ready   <= hdr_ready_next;
            s_payload_tready <= tready_next;
            bytes_left       <= bytes_left_next;
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        int_tvalid |-> int_ready_reg && int_tkeep == count2keep(keep2count(int_tkeep)));

endmodule

/* ip_tx_skid.sv */
`timescale 1ns/100ps

module ip_tx_skid
    import ip_stream_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic [data_w-1:0] int_tdata,
    input  logic [keep_w-1:0] int_tkeep,
    input  logic              int_tvalid,
    input  logic              int_tlast,
    input  logic              int_tuser,
    output logic              int_ready_reg,
    output logic              int_ready_early,
    output logic [data_w-1:0] m_payload_tdata,
    output logic [keep_w-1:0] m_payload_tkeep,
    output logic              m_payload_tvalid,
    output logic              m_payload_tlast,
    output logic              m_payload_tuser,
    input  logic              m_payload_tready
);

    logic [data_w-1:0] temp_tdata;
    logic [keep_w-1:0] temp_tkeep;
    logic              temp_tlast;
    logic              temp_tuser;
    logic              temp_tvalid;
    logic              out_valid_next;
    logic              temp_valid_next;
    logic              load_out;
    logic              load_temp;
    logic              temp_to_out;

    // temp stays free next cycle if sink takes data or nothing new can arrive
    assign int_ready_early = m_payload_tready
                          || (!temp_tvalid && (!m_payload_tvalid || !int_tvalid));

    always_comb begin
        out_valid_next  = m_payload_tvalid;
        temp_valid_next = temp_tvalid;
        load_out        = 1'b0;
        load_temp       = 1'b0;
        temp_to_out     = 1'b0;
        if (int_ready_reg) begin
            if (m_payload_tready || !m_payload_tvalid) begin
                out_valid_next = int_tvalid;
                load_out       = 1'b1;
            end else begin
                // word already in flight when the sink stalled
                temp_valid_next = int_tvalid;
                load_temp       = 1'b1;
            end
        end else if (m_payload_tready) begin
            out_valid_next  = temp_tvalid;
            temp_valid_next = 1'b0;
            temp_to_out     = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            m_payload_tvalid <= 1'b0;
            temp_tvalid      <= 1'b0;
            int_ready_reg    <= 1'b0;
        end else begin
            m_payload_tvalid <= out_valid_next;
            temp_tvalid      <= temp_valid_next;
            int_ready_reg    <= int_ready_early;
        end
    end

    always_ff @(posedge clk) begin
        if (load_out) begin
            m_payload_tdata <= int_tdata;
            m_payload_tkeep <= int_tkeep;
            m_payload_tlast <= int_tlast;
            m_payload_tuser <= int_tuser;
        end else if (temp_to_out) begin
            m_payload_tdata <= temp_tdata;
            m_payload_tkeep <= temp_tkeep;
            m_payload_tlast <= temp_tlast;
            m_payload_tuser <= temp_tuser;
        end
        if (load_temp) begin
            temp_tdata <= int_tdata;
            temp_tkeep <= int_tkeep;
            temp_tlast <= int_tlast;
            temp_tuser <= int_tuser;
        end
    end

    // a word caught by a stall never lands on a full temp entry
    assert property (@(posedge clk) disable iff (rst)
        load_temp && int_tvalid |-> !temp_tvalid);

endmodule

/* ip_eth_tx_top.sv */
`timescale 1ns/100ps

module ip_eth_tx_top
    import ip_hdr_pkg::*;
    import ip_stream_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   s_ip_hdr_valid,
    output logic                   s_ip_hdr_ready,
    input  logic [mac_w-1:0]       s_eth_dest_mac,
    input  logic [mac_w-1:0]       s_eth_src_mac,
    input  logic [ethertype_w-1:0] s_eth_type,
    input  logic [dscp_w-1:0]      s_ip_dscp,
    input  logic [ecn_w-1:0]       s_ip_ecn,
    input  logic [ip_len_w-1:0]    s_ip_length,
    input  logic [ip_len_w-1:0]    s_ip_identification,
    input  logic [flags_w-1:0]     s_ip_flags,
    input  logic [frag_w-1:0]      s_ip_fragment_offset,
    input  logic [ttl_w-1:0]       s_ip_ttl,
    input  logic [ttl_w-1:0]       s_ip_protocol,
    input  logic [ip_addr_w-1:0]   s_ip_source_ip,
    input  logic [ip_addr_w-1:0]   s_ip_dest_ip,
    input  logic [data_w-1:0]      s_payload_tdata,
    input  logic [keep_w-1:0]      s_payload_tkeep,
    input  logic                   s_payload_tvalid,
    output logic                   s_payload_tready,
    input  logic                   s_payload_tlast,
    output logic                   m_eth_hdr_valid,
    input  logic                   m_eth_hdr_ready,
    output logic [mac_w-1:0]       m_eth_dest_mac,
    output logic [mac_w-1:0]       m_eth_src_mac,
    output logic [ethertype_w-1:0] m_eth_type,
    output logic [data_w-1:0]      m_payload_tdata,
    output logic [keep_w-1:0]      m_payload_tkeep,
    output logic                   m_payload_tvalid,
    input  logic                   m_payload_tready,
    output logic                   m_payload_tlast,
    output logic                   m_payload_tuser,
    output logic                   error_early_term
);

    logic                 hdr_accept;
    logic [data_w-1:0]    hdr_word0;
    logic [data_w-1:0]    hdr_word1;
    logic [ip_addr_w-1:0] dest_ip_q;
    logic [ip_len_w-1:0]  ip_length_q;
    logic [data_w-1:0]    shift_tdata;
    logic [keep_w-1:0]    shift_tkeep;
    logic                 shift_tvalid;
    logic                 shift_tlast;
    logic                 shift_in_ready;
    logic                 save_en;
    logic                 flush;
    logic [data_w-1:0]    int_tdata;
    logic [keep_w-1:0]    int_tkeep;
    logic                 int_tvalid;
    logic                 int_tlast;
    logic                 int_tuser;
    logic                 int_ready_reg;
    logic                 int_ready_early;

    ip_hdr_capture i_ip_hdr_capture (
        .clk, .rst, .hdr_accept,
        .dest_mac(s_eth_dest_mac), .src_mac(s_eth_src_mac), .eth_type(s_eth_type),
        .dscp(s_ip_dscp), .ecn(s_ip_ecn), .length(s_ip_length),
        .identification(s_ip_identification), .flags(s_ip_flags),
        .frag_offset(s_ip_fragment_offset), .ttl(s_ip_ttl), .protocol(s_ip_protocol),
        .src_ip(s_ip_source_ip), .dest_ip(s_ip_dest_ip),
        .m_eth_hdr_ready, .m_eth_hdr_valid, .m_eth_dest_mac, .m_eth_src_mac, .m_eth_type,
        .hdr_word0, .hdr_word1, .dest_ip_q, .ip_length_q
    );

    ip_payload_shifter i_ip_payload_shifter (
        .clk, .rst,
        .s_tdata(s_payload_tdata), .s_tkeep(s_payload_tkeep),
        .s_tvalid(s_payload_tvalid), .s_tlast(s_payload_tlast),
        .save_en, .flush,
        .shift_tdata, .shift_tkeep, .shift_tvalid, .shift_tlast, .shift_in_ready
    );

    ip_tx_ctrl i_ip_tx_ctrl (
        .clk, .rst, .s_ip_hdr_valid, .s_ip_hdr_ready, .hdr_accept, .m_eth_hdr_valid,
        .hdr_word0, .hdr_word1, .dest_ip_q, .ip_length_q,
        .s_payload_tvalid, .s_payload_tlast, .s_payload_tready,
        .shift_tdata, .shift_tkeep, .shift_tvalid, .shift_tlast, .shift_in_ready,
        .save_en, .flush,
        .int_tdata, .int_tkeep, .int_tvalid, .int_tlast, .int_tuser,
        .int_ready_reg, .int_ready_early, .error_early_term
    );

    ip_tx_skid i_ip_tx_skid (
        .clk, .rst,
        .int_tdata, .int_tkeep, .int_tvalid, .int_tlast, .int_tuser,
        .int_ready_reg, .int_ready_early,
        .m_payload_tdata, .m_payload_tkeep, .m_payload_tvalid,
        .m_payload_tlast, .m_payload_tuser, .m_payload_tready
    );

endmodule

/* tb_ip_tx_model.svh */
`ifndef TB_IP_TX_MODEL_SVH
`define TB_IP_TX_MODEL_SVH

typedef logic [7:0] byte_q_t[$];

// ones-complement header checksum over the ten halfwords, checksum field as zero
function automatic logic [15:0] ip_checksum_ref(
    input logic [5:0] dscp, input logic [1:0] ecn, input logic [15:0] length,
    input logic [15:0] ident, input logic [2:0] flags, input logic [12:0] frag,
    input logic [7:0] ttl, input logic [7:0] proto, input logic [31:0] src,
    input logic [31:0] dst);
    logic [15:0] words [10];
    logic [31:0] sum;
    words[0] = {8'h45, dscp, ecn};
    words[1] = length;
    words[2] = ident;
    words[3] = {flags, frag};
    words[4] = {ttl, proto};
    words[5] = 16'h0000;
    words[6] = src[31:16];
    words[7] = src[15:0];
    words[8] = dst[31:16];
    words[9] = dst[15:0];
    sum = 32'd0;
    for (int i = 0; i < 10; i++) begin
        sum = sum + 32'(words[i]);
    end
    while (sum[31:16] != 16'd0) begin
        sum = 32'(sum[15:0]) + 32'(sum[31:16]);
    end
    return ~sum[15:0];
endfunction

// 20 header bytes in network order, then the payload cut to the length field
function automatic byte_q_t expected_bytes_ref(
    input logic [5:0] dscp, input logic [1:0] ecn, input logic [15:0] length,
    input logic [15:0] ident, input logic [2:0] flags, input logic [12:0] frag,
    input logic [7:0] ttl, input logic [7:0] proto, input logic [31:0] src,
    input logic [31:0] dst, input byte_q_t payload);
    byte_q_t q;
    logic [15:0] csum;
    int plen;
    csum = ip_checksum_ref(dscp, ecn, length, ident, flags, frag, ttl, proto, src, dst);
    q = {8'h45, 8'({dscp, ecn}), length[15:8], length[7:0], ident[15:8], ident[7:0],
         8'({flags, frag[12:8]}), frag[7:0], ttl, proto, csum[15:8], csum[7:0],
         src[31:24], src[23:16], src[15:8], src[7:0],
         dst[31:24], dst[23:16], dst[15:8], dst[7:0]};
    plen = int'(length) - 20;
    for (int i = 0; i < plen && i < payload.size(); i++) begin
        q.push_back(payload[i]);
    end
    return q;
endfunction

`endif

/* tb_ip_tx.sv */
`timescale 1ns/100ps

module tb_ip_tx
    import ip_hdr_pkg::*;
    import ip_stream_pkg::*;
;

    `include "tb_ip_tx_model.svh"

    localparam int timeout_cycles = 2000;

    logic clk;
    logic rst;
    logic s_ip_hdr_valid;
    logic s_ip_hdr_ready;
    logic [47:0] s_eth_dest_mac;
    logic [47:0] s_eth_src_mac;
    logic [15:0] s_eth_type;
    logic [5:0] s_ip_dscp;
    logic [1:0] s_ip_ecn;
    logic [15:0] s_ip_length;
    logic [15:0] s_ip_identification;
    logic [2:0] s_ip_flags;
    logic [12:0] s_ip_fragment_offset;
    logic [7:0] s_ip_ttl;
    logic [7:0] s_ip_protocol;
    logic [31:0] s_ip_source_ip;
    logic [31:0] s_ip_dest_ip;
    logic [63:0] s_payload_tdata;
    logic [7:0] s_payload_tkeep;
    logic s_payload_tvalid;
    logic s_payload_tready;
    logic s_payload_tlast;
    logic m_eth_hdr_valid;
    logic m_eth_hdr_ready;
    logic [47:0] m_eth_dest_mac;
    logic [47:0] m_eth_src_mac;
    logic [15:0] m_eth_type;
    logic [63:0] m_payload_tdata;
    logic [7:0] m_payload_tkeep;
    logic m_payload_tvalid;
    logic m_payload_tready;
    logic m_payload_tlast;
    logic m_payload_tuser;
    logic error_early_term;

    // expected frames, in order
    byte_q_t exp_bytes;
    int exp_len[$];
    logic exp_user[$];
    string exp_name[$];
    logic [47:0] exp_dest_mac[$];
    logic [47:0] exp_src_mac[$];
    logic [15:0] exp_type[$];
    byte_q_t got_bytes;
    int frames_sent;
    int frames_done;
    int errors_expected;
    int errors_seen;
    logic stall_mode;
    int nbytes;
    int flen;
    string fname;

    ip_eth_tx_top i_ip_eth_tx_top (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic stop_on_failure(input string msg);
        $display("%s", msg);
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (expected !== actual) begin
            stop_on_failure($sformatf("Error %s expected %0h actual %0h",
                                      name, expected, actual));
        end
    endtask

    // output side, sampled on the edge where the transfer happens
    always @(posedge clk) begin
        if (!rst && m_payload_tvalid && m_payload_tready) begin
            if (exp_len.size() == 0) begin
                stop_on_failure("payload output appeared with no frame expected");
            end
            nbytes = 0;
            for (int i = 0; i < 8; i++) begin
                if (m_payload_tkeep[i]) begin
                    got_bytes.push_back(m_payload_tdata[i*8 +: 8]);
                    nbytes++;
                end
            end
            check_value({exp_name[0], " keep"}, 64'((9'h1 << nbytes) - 9'h1),
                        64'(m_payload_tkeep));
            if (m_payload_tlast) begin
                fname = exp_name.pop_front();
                flen = exp_len.pop_front();
                check_value({fname, " length"}, 64'(flen), 64'(got_bytes.size()));
                for (int i = 0; i < flen; i++) begin
                    check_value($sformatf("%s byte %0d", fname, i),
                                64'(exp_bytes.pop_front()), 64'(got_bytes[i]));
                end
                check_value({fname, " tuser"}, 64'(exp_user.pop_front()),
                            64'(m_payload_tuser));
                got_bytes.delete();
                frames_done++;
            end
        end
        if (!rst && m_eth_hdr_valid && m_eth_hdr_ready) begin
            if (exp_type.size() == 0) begin
                stop_on_failure("ethernet header appeared with no frame expected");
            end
            check_value("eth dest mac", 64'(exp_dest_mac.pop_front()), 64'(m_eth_dest_mac));
            check_value("eth src mac", 64'(exp_src_mac.pop_front()), 64'(m_eth_src_mac));
            check_value("eth type", 64'(exp_type.pop_front()), 64'(m_eth_type));
        end
        if (!rst && error_early_term) begin
            errors_seen++;
        end
    end

    // both sinks stall at random when enabled
    always @(posedge clk) begin
        if (stall_mode) begin
            m_payload_tready <= ($urandom % 4) != 0;
            m_eth_hdr_ready <= ($urandom % 2) != 0;
        end else begin
            m_payload_tready <= 1'b1;
            m_eth_hdr_ready <= 1'b1;
        end
    end

    task automatic send_header(input byte_q_t payload);
        int cycles;
        byte_q_t exp;
        @(posedge clk);
        s_eth_dest_mac <= {$urandom, $urandom} & 48'hffff_ffff_ffff;
        s_eth_src_mac <= {$urandom, $urandom} & 48'hffff_ffff_ffff;
        s_eth_type <= 16'h0800;
        s_ip_dscp <= 6'($urandom);
        s_ip_ecn <= 2'($urandom);
        s_ip_identification <= 16'($urandom);
        s_ip_flags <= 3'($urandom);
        s_ip_fragment_offset <= 13'($urandom);
        s_ip_ttl <= 8'($urandom);
        s_ip_protocol <= 8'($urandom);
        s_ip_source_ip <= $urandom;
        s_ip_dest_ip <= $urandom;
        s_ip_hdr_valid <= 1'b1;
        @(negedge clk);
        exp = expected_bytes_ref(s_ip_dscp, s_ip_ecn, s_ip_length, s_ip_identification,
                                 s_ip_flags, s_ip_fragment_offset, s_ip_ttl,
                                 s_ip_protocol, s_ip_source_ip, s_ip_dest_ip, payload);
        foreach (exp[i]) begin
            exp_bytes.push_back(exp[i]);
        end
        exp_len.push_back(exp.size());
        exp_dest_mac.push_back(s_eth_dest_mac);
        exp_src_mac.push_back(s_eth_src_mac);
        exp_type.push_back(s_eth_type);
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
            if (cycles > timeout_cycles) begin
                stop_on_failure("timeout waiting for the header to be accepted");
            end
        end while (!s_ip_hdr_ready);
        s_ip_hdr_valid <= 1'b0;
    endtask

    task automatic send_payload(input byte_q_t payload);
        int nwords;
        int idx;
        int cycles;
        logic [63:0] d;
        logic [7:0] k;
        nwords = (payload.size() + 7) / 8;
        for (int w = 0; w < nwords; w++) begin
            d = '0;
            k = '0;
            for (int b = 0; b < 8; b++) begin
                idx = w * 8 + b;
                if (idx < payload.size()) begin
                    d[b*8 +: 8] = payload[idx];
                    k[b] = 1'b1;
                end
            end
            s_payload_tdata <= d;
            s_payload_tkeep <= k;
            s_payload_tlast <= w == nwords - 1;
            s_payload_tvalid <= 1'b1;
            cycles = 0;
            do begin
                @(posedge clk);
                cycles++;
                if (cycles > timeout_cycles) begin
                    stop_on_failure("timeout waiting for the payload input to be taken");
                end
            end while (!s_payload_tready);
        end
        s_payload_tvalid <= 1'b0;
        s_payload_tlast <= 1'b0;
    endtask

    // plen is the payload length in the header, sent what is really offered
    task automatic run_frame(input string name, input int plen, input int sent);
        byte_q_t payload;
        for (int i = 0; i < sent; i++) begin
            payload.push_back(8'($urandom));
        end
        s_ip_length <= 16'(20 + plen);
        exp_name.push_back(name);
        exp_user.push_back(sent < plen);
        if (sent < plen) begin
            errors_expected++;
        end
        frames_sent++;
        send_header(payload);
        send_payload(payload);
    endtask

    task automatic wait_frames_done();
        int cycles;
        cycles = 0;
        while (frames_done < frames_sent) begin
            @(posedge clk);
            cycles++;
            if (cycles > timeout_cycles) begin
                stop_on_failure("timeout waiting for frames to leave the output");
            end
        end
    endtask

    initial begin
        void'($urandom(32'h71e2));
        rst = 1'b1;
        s_ip_hdr_valid = 1'b0;
        s_eth_dest_mac = '0;
        s_eth_src_mac = '0;
        s_eth_type = '0;
        s_ip_dscp = '0;
        s_ip_ecn = '0;
        s_ip_length = '0;
        s_ip_identification = '0;
        s_ip_flags = '0;
        s_ip_fragment_offset = '0;
        s_ip_ttl = '0;
        s_ip_protocol = '0;
        s_ip_source_ip = '0;
        s_ip_dest_ip = '0;
        s_payload_tdata = '0;
        s_payload_tkeep = '0;
        s_payload_tvalid = 1'b0;
        s_payload_tlast = 1'b0;
        m_eth_hdr_ready = 1'b1;
        m_payload_tready = 1'b0;
        stall_mode = 1'b0;
        frames_sent = 0;
        frames_done = 0;
        errors_expected = 0;
        errors_seen = 0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;

        for (int n = 1; n <= 40; n++) begin
            run_frame($sformatf("length %0d", n), n, n);
        end
        wait_frames_done();

        stall_mode <= 1'b1;
        for (int n = 1; n <= 40; n += 3) begin
            run_frame($sformatf("stall length %0d", n), n, n);
        end
        wait_frames_done();
        stall_mode <= 1'b0;

        run_frame("excess input", 10, 25);
        run_frame("after excess", 17, 17);
        run_frame("excess long", 3, 30);
        run_frame("short input", 30, 13);
        run_frame("after short", 9, 9);
        wait_frames_done();
        repeat (5) @(posedge clk);
        check_value("early termination pulses", 64'(errors_expected), 64'(errors_seen));
        check_value("ethernet headers not seen", 64'(0), 64'(exp_type.size()));

        $display("sim passed");
        $finish;
    end

endmodule

/* all.f */
+incdir+.
ip_hdr_pkg.sv
ip_stream_pkg.sv
ip_hdr_capture.sv
ip_payload_shifter.sv
ip_tx_ctrl.sv
ip_tx_skid.sv
ip_eth_tx_top.sv
tb_ip_tx.sv

/* run_sim.sh */
#!/bin/bash
set -u
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f all.f --top-module tb_ip_tx \
    -Mdir obj_dir -o sim_tb_ip_tx
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

output=$(./obj_dir/sim_tb_ip_tx 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    exit 1
fi
if echo "$output" | grep -qx "sim passed"; then
    exit 0
fi
exit 1
